// ==== project.f ====
+incdir+source
source/fib_types_pkg.sv
source/fib_ctrl_pkg.sv
source/fib_hash.sv
source/fib_valid_store.sv
source/fib_rx_parser.sv
source/fib_lpm_search.sv
source/fib_spi_tx.sv
source/fib_table.sv
tests/fib_table_chk.sv
tests/fib_table_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the forwarding table testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module fib_table_tb -Mdir obj_dir -o fib_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fib_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Done: errors found" "$log_file"; then
    exit 1
fi

if ! grep -q "Done: no errors" "$log_file"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0

// ==== source/fib_ctrl_pkg.sv ====
// Record and result structs plus state encodings of the three FSMs
package fib_ctrl_pkg;

    import fib_types_pkg::*;

    // Prefix as exchanged with the pending-interest table
    typedef struct packed {
        meta_t   meta;
        prefix_t prefix;
    } fib_rec_t;

    // Lookup reply, field order is the send order
    typedef struct packed {
        meta_t   meta;
        prefix_t prefix;
        prefix_t cand;
    } lpm_result_t;

    // Serial input parser
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_META,
        RX_PFX,
        RX_READY,
        RX_HASH,
        RX_WRITE
    } rx_state_t;

    // Longest-prefix search
    typedef enum logic [1:0] {
        LPM_IDLE,
        LPM_HASH,
        LPM_CHECK,
        LPM_HOLD
    } lpm_state_t;

    // Reply serializer
    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

endpackage

// ==== source/fib_hash.sv ====
// Registered XOR fold of a prefix into a column index
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_hash (
    input  logic                   clk,
    input  logic                   rst,
    input  fib_types_pkg::prefix_t prefix,
    output fib_types_pkg::hash_t   hash
);
    import fib_types_pkg::*;

    localparam int PREFIX_W = `FIB_PREFIX_BYTES * 8;
    // Last slice is partial, zero-extended by the shift
    localparam int SLICES   = (PREFIX_W + `FIB_HASH_W - 1) / `FIB_HASH_W;

    hash_t fold;

    // Slices from bit 0 upward
    always_comb begin
        fold = '0;
        for (int i = 0; i < SLICES; i++) begin
            fold ^= hash_t'(prefix >> (i * `FIB_HASH_W));
        end
    end

    // One cycle of latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= fold;
        end
    end

endmodule

// ==== source/fib_lpm_search.sv ====
// Longest-prefix search FSM with result hold
`timescale 1ns/1ps

module fib_lpm_search (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fib_out,
    input  fib_ctrl_pkg::fib_rec_t    pit_in,
    input  logic                      tx_busy,
    output fib_types_pkg::plen_t      look_row,
    output fib_types_pkg::hash_t      look_col,
    input  logic                      look_hit,
    output logic                      res_valid,
    output fib_ctrl_pkg::lpm_result_t res
);
    import fib_types_pkg::*;
    import fib_ctrl_pkg::*;

    lpm_state_t state;
    fib_rec_t   req;
    prefix_t    cand;
    plen_t      len;
    hash_t      cand_hash;
    logic       found;
    logic       start;

    // Requests outside idle are dropped
    assign start = (state == LPM_IDLE) && fib_out;

    // Hash follows the candidate register
    fib_hash u_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (cand),
        .hash   (cand_hash)
    );

    // Table probe at the current length
    assign look_row = len;
    assign look_col = cand_hash;

    // Stop on a hit or at length 0
    assign found = look_hit || (len == '0);

    // Control FSM and length
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= LPM_IDLE;
            len   <= '0;
        end else begin
            case (state)
                LPM_IDLE: begin
                    if (start) begin
                        state <= LPM_HASH;
                        len   <= pit_in.meta[$bits(plen_t)-1:0];
                    end
                end
                LPM_HASH: begin
                    state <= LPM_CHECK;
                end
                LPM_CHECK: begin
                    if (found) begin
                        state <= LPM_HOLD;
                    end else begin
                        // One length shorter
                        state <= LPM_HASH;
                        len   <= len - 1'b1;
                    end
                end
                LPM_HOLD: begin
                    // Wait for the serializer to go idle
                    if (!tx_busy) begin
                        state <= LPM_IDLE;
                    end
                end
                default: begin
                    state <= LPM_IDLE;
                end
            endcase
        end
    end

    // Request and candidate
    always_ff @(posedge clk) begin
        if (start) begin
            req  <= pit_in;
            cand <= pit_in.prefix;
        end else if ((state == LPM_CHECK) && !found) begin
            // Drop the bit at the missed length
            cand[len] <= 1'b0;
        end
    end

    // Result handed over once the serializer is free
    assign res_valid = (state == LPM_HOLD) && !tx_busy;

    always_comb begin
        res.meta   = req.meta;
        res.prefix = req.prefix;
        res.cand   = cand;
    end

endmodule

// ==== source/fib_rx_parser.sv ====
// Serial packet parser with record forwarding and learn write
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_rx_parser (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx_valid,
    input  fib_types_pkg::byte_t   spi_rx_byte,
    output logic                   prefix_ready,
    output fib_ctrl_pkg::fib_rec_t pit_out,
    output logic                   learn_we,
    output fib_types_pkg::plen_t   learn_row,
    output fib_types_pkg::hash_t   learn_col
);
    import fib_types_pkg::*;
    import fib_ctrl_pkg::*;

    localparam int CNT_W = $clog2(`FIB_PREFIX_BYTES);

    rx_state_t        state;
    logic [CNT_W-1:0] byte_cnt;
    fib_rec_t         rec;
    prefix_t          hash_in;
    hash_t            rec_hash;

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RX_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (rx_valid) begin
                        state <= RX_META;
                    end
                end
                RX_META: begin
                    // Prefix bytes follow, counted down to zero
                    state    <= RX_PFX;
                    byte_cnt <= CNT_W'(`FIB_PREFIX_BYTES - 1);
                end
                RX_PFX: begin
                    if (byte_cnt == '0) begin
                        state <= RX_READY;
                    end
                    byte_cnt <= byte_cnt - 1'b1;
                end
                RX_READY: begin
                    state <= RX_HASH;
                end
                RX_HASH: begin
                    state <= RX_WRITE;
                end
                RX_WRITE: begin
                    state <= RX_IDLE;
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Record assembly
    always_ff @(posedge clk) begin
        if (state == RX_META) begin
            rec.meta <= spi_rx_byte;
        end
        if (state == RX_PFX) begin
            // MSB first, so shift up and append
            rec.prefix <= {rec.prefix[$bits(prefix_t)-9:0], spi_rx_byte};
        end
    end

    // Prefix goes to the hash only in the hash state
    assign hash_in = (state == RX_HASH) ? rec.prefix : '0;

    fib_hash u_hash (
        .clk    (clk),
        .rst    (rst),
        .prefix (hash_in),
        .hash   (rec_hash)
    );

    // Ready pulse carries the whole record
    assign prefix_ready = (state == RX_READY);
    assign pit_out      = rec;

    // Hash is back one cycle after the hash state
    assign learn_we  = (state == RX_WRITE);
    assign learn_row = rec.meta[`FIB_LEN_W-1:0];
    assign learn_col = rec_hash;

endmodule

// ==== source/fib_settings.svh ====
// Size and width macros for the forwarding table
`ifndef FIB_SETTINGS_SVH
`define FIB_SETTINGS_SVH

// Name prefix size in bytes
`define FIB_PREFIX_BYTES 8

// Column index width, 1024 columns
`define FIB_HASH_W 10

// Length field width, 64 rows
`define FIB_LEN_W 6

// Reply size: metadata, original prefix, final candidate
`define FIB_RESULT_BYTES 17

`endif

// ==== source/fib_spi_tx.sv ====
// Reply serializer, 17 bytes per search result
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_spi_tx (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      res_valid,
    input  fib_ctrl_pkg::lpm_result_t res,
    output logic                      tx_busy,
    output logic                      spi_tx_valid,
    output fib_types_pkg::byte_t      spi_tx_byte
);
    import fib_types_pkg::*;
    import fib_ctrl_pkg::*;

    localparam int RES_W = `FIB_RESULT_BYTES * 8;
    localparam int CNT_W = $clog2(`FIB_RESULT_BYTES);

    tx_state_t        state;
    logic [CNT_W-1:0] byte_cnt;
    logic [RES_W-1:0] shreg;

    // Control FSM, byte count runs 16 down to 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (res_valid) begin
                        state    <= TX_SEND;
                        byte_cnt <= CNT_W'(`FIB_RESULT_BYTES - 1);
                    end
                end
                TX_SEND: begin
                    if (byte_cnt == '0) begin
                        state <= TX_IDLE;
                    end
                    byte_cnt <= byte_cnt - 1'b1;
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Metadata leaves first, then both prefixes MSB first
    always_ff @(posedge clk) begin
        if ((state == TX_IDLE) && res_valid) begin
            shreg <= res;
        end else if (state == TX_SEND) begin
            shreg <= shreg << 8;
        end
    end

    assign spi_tx_byte  = shreg[RES_W-1 -: 8];
    assign spi_tx_valid = (state == TX_SEND);
    // Busy for the whole burst
    assign tx_busy      = (state == TX_SEND);

endmodule

// ==== source/fib_table.sv ====
// Forwarding table top level wiring parser, grid, search and serializer
`timescale 1ns/1ps

module fib_table (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx_valid,
    input  fib_types_pkg::byte_t   spi_rx_byte,
    output logic                   prefix_ready,
    output fib_ctrl_pkg::fib_rec_t pit_out,
    input  logic                   fib_out,
    input  fib_ctrl_pkg::fib_rec_t pit_in,
    output logic                   spi_tx_valid,
    output fib_types_pkg::byte_t   spi_tx_byte
);
    import fib_types_pkg::*;
    import fib_ctrl_pkg::*;

    // Learn port
    logic        learn_we;
    plen_t       learn_row;
    hash_t       learn_col;

    // Lookup port
    plen_t       look_row;
    hash_t       look_col;
    logic        look_hit;

    // Search to serializer
    logic        res_valid;
    lpm_result_t res;
    logic        tx_busy;

    fib_rx_parser u_rx (
        .clk          (clk),
        .rst          (rst),
        .rx_valid     (rx_valid),
        .spi_rx_byte  (spi_rx_byte),
        .prefix_ready (prefix_ready),
        .pit_out      (pit_out),
        .learn_we     (learn_we),
        .learn_row    (learn_row),
        .learn_col    (learn_col)
    );

    fib_valid_store u_store (
        .clk       (clk),
        .rst       (rst),
        .learn_we  (learn_we),
        .learn_row (learn_row),
        .learn_col (learn_col),
        .look_row  (look_row),
        .look_col  (look_col),
        .look_hit  (look_hit)
    );

    fib_lpm_search u_lpm (
        .clk       (clk),
        .rst       (rst),
        .fib_out   (fib_out),
        .pit_in    (pit_in),
        .tx_busy   (tx_busy),
        .look_row  (look_row),
        .look_col  (look_col),
        .look_hit  (look_hit),
        .res_valid (res_valid),
        .res       (res)
    );

    fib_spi_tx u_tx (
        .clk          (clk),
        .rst          (rst),
        .res_valid    (res_valid),
        .res          (res),
        .tx_busy      (tx_busy),
        .spi_tx_valid (spi_tx_valid),
        .spi_tx_byte  (spi_tx_byte)
    );

endmodule

// ==== source/fib_types_pkg.sv ====
// Vector typedefs for bytes, prefixes, hashes, lengths and metadata
`include "fib_settings.svh"

package fib_types_pkg;

    // One byte on either serial side
    typedef logic [7:0] byte_t;

    // Full name prefix, MSB first on the wire
    typedef logic [`FIB_PREFIX_BYTES*8-1:0] prefix_t;

    // Table column index
    typedef logic [`FIB_HASH_W-1:0] hash_t;

    // Prefix length, also the table row
    typedef logic [`FIB_LEN_W-1:0] plen_t;

    // Metadata byte, length in the low bits
    typedef logic [7:0] meta_t;

endpackage

// ==== source/fib_valid_store.sv ====
// Valid-bit grid, one row per length and one column per hash
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_valid_store (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 learn_we,
    input  fib_types_pkg::plen_t learn_row,
    input  fib_types_pkg::hash_t learn_col,
    input  fib_types_pkg::plen_t look_row,
    input  fib_types_pkg::hash_t look_col,
    output logic                 look_hit
);
    import fib_types_pkg::*;

    localparam int ROWS = 2 ** `FIB_LEN_W;
    localparam int COLS = 2 ** `FIB_HASH_W;

    // 64 x 1024 bits
    logic [COLS-1:0] grid [ROWS];

    // Bits are only ever set, cleared by reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < ROWS; r++) begin
                grid[r] <= '0;
            end
        end else if (learn_we) begin
            grid[learn_row][learn_col] <= 1'b1;
        end
    end

    // Combinational read for the search
    assign look_hit = grid[look_row][look_col];

endmodule

// ==== tests/fib_table_chk.sv ====
// Protocol assertions for the forwarding table top level and their bind
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_table_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 prefix_ready,
    input logic                 spi_tx_valid,
    input fib_types_pkg::byte_t spi_tx_byte
);
    // Cycles spent in the current valid run
    int run_len;

    // Number of failed assertions
    int fail_count = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_len <= 0;
        end else if (spi_tx_valid) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    // Reply burst never runs past its byte count
    burst_not_long: assert property (@(posedge clk) disable iff (rst)
        spi_tx_valid |-> (run_len < `FIB_RESULT_BYTES))
        else begin
            fail_count++;
            $error("spi_tx_valid stayed high past the reply length");
        end

    // Falling edge only after the full burst
    burst_not_short: assert property (@(posedge clk) disable iff (rst)
        (!spi_tx_valid && (run_len != 0)) |-> (run_len == `FIB_RESULT_BYTES))
        else begin
            fail_count++;
            $error("spi_tx_valid burst ended early");
        end

    ready_single: assert property (@(posedge clk) disable iff (rst)
        prefix_ready |=> !prefix_ready)
        else begin
            fail_count++;
            $error("prefix_ready high for more than one cycle");
        end

    tx_byte_known: assert property (@(posedge clk) disable iff (rst)
        spi_tx_valid |-> !$isunknown(spi_tx_byte))
        else begin
            fail_count++;
            $error("spi_tx_byte has unknown bits while valid");
        end

    // Strobes quiet while reset is held
    reset_quiet: assert property (@(posedge clk)
        rst |-> (!prefix_ready && !spi_tx_valid))
        else begin
            fail_count++;
            $error("output strobe high during reset");
        end

endmodule

bind fib_table fib_table_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .prefix_ready (prefix_ready),
    .spi_tx_valid (spi_tx_valid),
    .spi_tx_byte  (spi_tx_byte)
);

// ==== tests/fib_table_tb.sv ====
// Forwarding table testbench with clock, reset, stimulus, reference model and reply checker
`timescale 1ns/1ps
`include "fib_settings.svh"

module fib_table_tb;
    import fib_types_pkg::*;
    import fib_ctrl_pkg::*;

    localparam int RES_W = `FIB_RESULT_BYTES * 8;
    localparam int ROWS  = 2 ** `FIB_LEN_W;

    logic     clk;
    logic     rst;
    logic     rx_valid;
    byte_t    spi_rx_byte;
    logic     prefix_ready;
    fib_rec_t pit_out;
    logic     fib_out;
    fib_rec_t pit_in;
    logic     spi_tx_valid;
    byte_t    spi_tx_byte;

    // Model grid, pending replies, last reply seen on the wire
    logic [2**`FIB_HASH_W-1:0] ref_grid [ROWS];
    lpm_result_t exp_q[$];
    lpm_result_t last_reply;

    logic [31:0] lfsr;
    logic        hung;
    int value_errs = 0;
    int timeouts = 0;
    int other_errs = 0;
    int packets_sent = 0;
    int ready_pulses = 0;
    int replies_seen = 0;

    fib_table fib_table_inst (
        .clk          (clk),
        .rst          (rst),
        .rx_valid     (rx_valid),
        .spi_rx_byte  (spi_rx_byte),
        .prefix_ready (prefix_ready),
        .pit_out      (pit_out),
        .fib_out      (fib_out),
        .pit_in       (pit_in),
        .spi_tx_valid (spi_tx_valid),
        .spi_tx_byte  (spi_tx_byte)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    // XOR of slices from bit 0 up until the rest is zero
    function automatic hash_t ref_hash(input prefix_t p);
        hash_t   h;
        prefix_t rest;
        h    = '0;
        rest = p;
        while (rest != '0) begin
            h    = h ^ rest[`FIB_HASH_W-1:0];
            rest = rest >> `FIB_HASH_W;
        end
        return h;
    endfunction

    // Longest match on the model grid
    function automatic lpm_result_t ref_reply(input fib_rec_t rq);
        lpm_result_t r;
        int          len;
        r.meta   = rq.meta;
        r.prefix = rq.prefix;
        r.cand   = rq.prefix;
        len      = int'(rq.meta[`FIB_LEN_W-1:0]);
        while ((len > 0) && (ref_grid[len][ref_hash(r.cand)] == 1'b0)) begin
            r.cand[len] = 1'b0;
            len--;
        end
        return r;
    endfunction

    task automatic check_rec(input string name, input fib_rec_t got, input fib_rec_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Inputs move 5 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // Strobe then metadata then prefix MSB first
    task automatic send_packet(input meta_t meta, input prefix_t p);
        next_cycle();
        rx_valid = 1'b1;
        next_cycle();
        rx_valid    = 1'b0;
        spi_rx_byte = meta;
        for (int i = `FIB_PREFIX_BYTES - 1; i >= 0; i--) begin
            next_cycle();
            spi_rx_byte = p[i*8 +: 8];
        end
        next_cycle();
        spi_rx_byte = '0;
    endtask

    task automatic learn(input meta_t meta, input prefix_t p);
        fib_rec_t exp;
        logic     seen;
        if (hung) begin
            return;
        end
        exp.meta   = meta;
        exp.prefix = p;
        send_packet(meta, p);
        packets_sent++;
        seen = 1'b0;
        for (int i = 0; (i < 20) && !seen; i++) begin
            @(negedge clk);
            seen = prefix_ready;
        end
        if (!seen) begin
            timeouts++;
            hung = 1'b1;
            $display("Timeout at %0t: no prefix_ready after a packet", $time);
            return;
        end
        check_rec("pit_out", pit_out, exp);
        ref_grid[meta[`FIB_LEN_W-1:0]][ref_hash(p)] = 1'b1;
        // Parser busy with hash and write
        repeat (3) @(posedge clk);
    endtask

    task automatic lookup(input meta_t meta, input prefix_t p, output lpm_result_t r);
        fib_rec_t rq;
        int       target;
        r = '0;
        if (hung) begin
            return;
        end
        rq.meta   = meta;
        rq.prefix = p;
        exp_q.push_back(ref_reply(rq));
        target = replies_seen + 1;
        next_cycle();
        fib_out = 1'b1;
        pit_in  = rq;
        next_cycle();
        fib_out = 1'b0;
        // Up to 64 lengths at two cycles each plus the burst
        for (int i = 0; (i < 400) && (replies_seen < target); i++) begin
            @(posedge clk);
        end
        if (replies_seen < target) begin
            timeouts++;
            hung = 1'b1;
            $display("Timeout at %0t: lookup reply never finished", $time);
        end
        r = last_reply;
    endtask

    // Collects each burst at the falling clock edge and compares it
    initial begin : reply_monitor
        byte_t            burst[$];
        lpm_result_t      exp;
        logic [RES_W-1:0] exp_v;
        logic [RES_W-1:0] got_v;
        forever begin
            @(negedge clk);
            if (prefix_ready) begin
                ready_pulses++;
            end
            if (spi_tx_valid) begin
                burst.push_back(spi_tx_byte);
            end else if (burst.size() != 0) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Reply burst at %0t with no lookup pending", $time);
                end else if (burst.size() != `FIB_RESULT_BYTES) begin
                    exp = exp_q.pop_front();
                    other_errs++;
                    $display("Reply at %0t had %0d bytes", $time, burst.size());
                end else begin
                    exp   = exp_q.pop_front();
                    exp_v = exp;
                    got_v = '0;
                    for (int k = 0; k < `FIB_RESULT_BYTES; k++) begin
                        check_byte($sformatf("spi_tx_byte[%0d]", k), burst[k],
                                   exp_v[RES_W-1-8*k -: 8]);
                        got_v = {got_v[RES_W-9:0], burst[k]};
                    end
                    last_reply = got_v;
                end
                burst.delete();
                replies_seen++;
            end
        end
    end

    task automatic check_idle();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (prefix_ready || spi_tx_valid) begin
                other_errs++;
                $display("Output strobe high at %0t with idle inputs", $time);
            end
        end
    endtask

    task automatic directed_tests();
        logic [63:0] v;
        prefix_t     p;
        prefix_t     mask;
        lpm_result_t r;
        // Empty table drops bits 1 to 35
        take_bits(64, v);
        p = v;
        lookup(8'ha3, p, r);
        mask = ((64'h1 << 35) - 1) << 1;
        if (!hung) begin
            check_rec("reply candidate", {r.meta, r.cand}, {8'ha3, p & ~mask});
        end
        // Exact match at length 40
        take_bits(64, v);
        p = v;
        learn(8'h68, p);
        lookup(8'h68, p, r);
        if (!hung) begin
            check_rec("reply candidate", {r.meta, r.cand}, {8'h68, p});
        end
        // Learned at 12 and searched from 25 with bits 13 to 25 zero in the entry
        take_bits(64, v);
        mask = ((64'h1 << 13) - 1) << 13;
        p    = v & ~mask;
        learn(8'h0c, p);
        take_bits(64, v);
        lookup(8'h19, p | (v & mask), r);
        if (!hung) begin
            check_rec("reply candidate", {r.meta, r.cand}, {8'h19, p});
        end
        // Bits 20 and 30 cancel in the fold so the hashes collide
        take_bits(64, v);
        p = v;
        learn(8'h32, p);
        lookup(8'h32, p ^ (64'h1 << 20) ^ (64'h1 << 30), r);
        if (!hung) begin
            check_rec("reply candidate", {r.meta, r.cand},
                      {8'h32, p ^ (64'h1 << 20) ^ (64'h1 << 30)});
        end
    endtask

    task automatic random_tests();
        logic [63:0] v;
        prefix_t     p;
        prefix_t     q;
        meta_t       m;
        meta_t       m2;
        lpm_result_t r;
        for (int i = 0; (i < 30) && !hung; i++) begin
            take_bits(64, v);
            p = v;
            take_bits(8, v);
            m = v[7:0];
            learn(m, p);
            take_bits(8, v);
            m2 = v[7:0];
            take_bits(2, v);
            case (v[1:0])
                2'd0: q = p;
                2'd1: begin
                    q  = p;
                    m2 = m;
                end
                2'd2: begin
                    // Sparse bit flips
                    take_bits(64, v);
                    q = p ^ (v & (v >> 3) & (v >> 5));
                end
                default: begin
                    take_bits(64, v);
                    q = v;
                end
            endcase
            lookup(m2, q, r);
        end
    endtask

    task automatic finish_run();
        int assert_errs;
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d lookup replies never arrived", exp_q.size());
        end
        if (ready_pulses != packets_sent) begin
            other_errs++;
            $display("%0d prefix_ready pulses for %0d packets", ready_pulses, packets_sent);
        end
        assert_errs = fib_table_inst.u_chk.fail_count;
        $display(
            "Closing: %0d value errors, %0d timeouts, %0d other errors, %0d assertion errors",
            value_errs, timeouts, other_errs, assert_errs);
        if ((value_errs + timeouts + other_errs + assert_errs) == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        lfsr        = 32'h5f49;
        hung        = 1'b0;
        rst         = 1'b1;
        rx_valid    = 1'b0;
        spi_rx_byte = '0;
        fib_out     = 1'b0;
        pit_in      = '0;
        for (int row = 0; row < ROWS; row++) begin
            ref_grid[row] = '0;
        end
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        check_idle();
        directed_tests();
        random_tests();
        finish_run();
    end

endmodule
